//--- common/sched_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tile scheduler package
// Job configuration, buffer flags, FSM encoding
// and the strobe bundles shared by the scheduler
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package sched_pkg;

  // Every iteration count in the scheduler uses this width
  localparam int unsigned ITER_W = 16;

  // Default systolic array geometry and engine pipeline depth
  localparam int unsigned DEF_HEIGHT    = 4;
  localparam int unsigned DEF_WIDTH     = 4;
  localparam int unsigned DEF_PIPE_REGS = 3;

  typedef struct packed {
    logic [ITER_W-1:0] x_rows;
    logic [ITER_W-1:0] x_cols;
    logic [ITER_W-1:0] w_rows;
    logic [ITER_W-1:0] w_cols;
    logic              y_en;
    logic              start;
    logic              clear;
    logic [1:0]        spare;
  } sched_cfg_t;

  // In the buffer status x_empty is a single-cycle pulse
  typedef struct packed {
    logic x_full;
    logic x_empty;
    logic x_valid;
    logic w_valid;
    logic y_loaded;
  } buf_flgs_t;

  typedef enum logic [1:0] {
    IDLE,
    PRELOAD,
    LOAD_W,
    WAIT
  } sched_state_e;

  typedef struct packed {
    logic in_load_w;
    logic advance;
    logic preload_exit;
    logic start_comp;
  } fsm_ctrl_t;

  typedef struct packed {
    logic load;
    logic h_shift;
    logic rst_w_index;
    logic pad_setup;
  } x_strb_t;

endpackage

//--- flist.f
+incdir+sim
common/sched_pkg.sv
verilog/tile_counter.sv
fsm/sched_fsm.sv
x_ctrl/x_ctrl.sv
w_ctrl/w_ctrl.sv
z_ctrl/z_ctrl.sv
verilog/sched_top.sv
sim/tb_sched.sv

//--- fsm/sched_fsm.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Scheduler control FSM
// Steps through preload, weight load and pipeline
// wait, and decides when the engine must stall
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module sched_fsm #(
  parameter int unsigned NumPipeRegs = sched_pkg::DEF_PIPE_REGS
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  sched_pkg::sched_cfg_t cfg_i,
  input  sched_pkg::buf_flgs_t  flgs_i,
  input  logic                  x_check_i,
  input  logic                  w_done_i,
  input  logic                  y_check_i,
  output sched_pkg::fsm_ctrl_t  ctrl_o,
  output logic                  reg_enable_o
);

  localparam int unsigned     CntW     = $clog2(NumPipeRegs + 1);
  localparam logic [CntW-1:0] LastWait = CntW'(NumPipeRegs);

  sched_pkg::sched_state_e state_q, state_d;

  logic [CntW-1:0] wait_q;
  logic            first_load_q, computing_q, reg_enable_q;
  logic            stall, advance, in_load_w, preload_done;

  assign in_load_w = state_q == sched_pkg::LOAD_W;

  // Only a weight load can stall when the W row is missing or X or Y is not ready
  assign stall = in_load_w && ((!flgs_i.w_valid && !w_done_i) ||
                               (x_check_i && !flgs_i.x_full) ||
                               (y_check_i && !flgs_i.y_loaded));

  assign advance      = computing_q && !stall;
  assign preload_done = flgs_i.x_full && (flgs_i.y_loaded || !cfg_i.y_en);

  always_comb begin
    state_d = state_q;
    case (state_q)
      sched_pkg::IDLE: begin
        if (cfg_i.start) state_d = sched_pkg::PRELOAD;
      end
      sched_pkg::PRELOAD: begin
        if (preload_done) state_d = sched_pkg::LOAD_W;
      end
      sched_pkg::LOAD_W: begin
        if (!stall) state_d = sched_pkg::WAIT;
      end
      sched_pkg::WAIT: begin
        if (wait_q == LastWait) state_d = sched_pkg::LOAD_W;
      end
      default: state_d = sched_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= sched_pkg::IDLE;
      wait_q       <= '0;
      first_load_q <= 1'b1;
      computing_q  <= 1'b0;
      reg_enable_q <= 1'b0;
    end else if (cfg_i.clear) begin
      state_q      <= sched_pkg::IDLE;
      wait_q       <= '0;
      first_load_q <= 1'b1;
      computing_q  <= 1'b0;
      reg_enable_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      reg_enable_q <= advance;
      // The wait counter runs across LOAD_W and WAIT, so WAIT lasts NumPipeRegs cycles
      if (advance) begin
        wait_q <= (wait_q == LastWait) ? '0 : wait_q + 1'b1;
      end
      if (in_load_w && !stall) first_load_q <= 1'b0;
      if (ctrl_o.preload_exit) computing_q <= 1'b1;
    end
  end

  assign ctrl_o.in_load_w    = in_load_w;
  assign ctrl_o.advance      = advance;
  assign ctrl_o.preload_exit = (state_q == sched_pkg::PRELOAD) && preload_done;
  assign ctrl_o.start_comp   = first_load_q && in_load_w && !stall;
  assign reg_enable_o        = reg_enable_q;

  a_hold_on_stall : assert property (@(posedge clk_i) disable iff (!rst_ni || cfg_i.clear)
    in_load_w && stall |=> state_q == sched_pkg::LOAD_W)
    else $error("sched_fsm: weight load left while stalled");

endmodule

//--- run.sh
#!/bin/sh
# Build and run the tile scheduler testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -j 0 \
  --top-module tb_sched -f flist.f -o sim_tb_sched

./obj_dir/sim_tb_sched | tee sim.log

# The run passes only when the testbench reported success
grep -qF "*** TEST PASSED ***" sim.log

//--- sim/sched_model.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tile scheduler reference model
// Expected event counts and cycle budgets
// derived from a job configuration
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef SCHED_MODEL_SVH
`define SCHED_MODEL_SVH

// Expected counts of the running job
int unsigned exp_loads  = 0;
int unsigned exp_pushes = 0;

// The monitor updates these observed events on the falling edge
int unsigned load_cnt  = 0;
int unsigned push_cnt  = 0;
int unsigned last_load = 0;
logic        x_seen    = 1'b0;
logic        y_seen    = 1'b0;
logic        done_seen = 1'b0;

// Every W row of every column tile is loaded once per X row tile
function automatic int unsigned w_steps(input sched_pkg::sched_cfg_t c);
  return 32'(c.w_rows) * 32'(c.w_cols) * 32'(c.x_rows);
endfunction

// Each completed column tile drains one Y tile of HEIGHT rows
function automatic int unsigned y_pushes(input sched_pkg::sched_cfg_t c);
  return HEIGHT * 32'(c.w_cols) * 32'(c.x_rows);
endfunction

// Budget of eight load periods per W step
function automatic int unsigned job_cycles(input sched_pkg::sched_cfg_t c);
  return w_steps(c) * (NUM_PIPE + 1) * 8 + JOB_MARGIN;
endfunction

function automatic int unsigned watchdog_cycles();
  int unsigned total;
  total = 500;
  for (int j = 0; j < NUM_JOBS; j++) begin
    total = total + job_cycles(job_cfg[j]) + DRAIN + 8;
  end
  return total;
endfunction

task start_model(input sched_pkg::sched_cfg_t c);
  exp_loads  = w_steps(c);
  exp_pushes = y_pushes(c);
  load_cnt   = 0;
  push_cnt   = 0;
  last_load  = 0;
  x_seen     = 1'b0;
  y_seen     = 1'b0;
  done_seen  = 1'b0;
endtask

`endif

//--- sim/tb_sched.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tile scheduler testbench
// Emulates the X, W and Y buffers with random
// flags and checks the strobes against a model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module tb_sched;

  localparam int unsigned HEIGHT     = sched_pkg::DEF_HEIGHT;
  localparam int unsigned WIDTH      = sched_pkg::DEF_WIDTH;
  localparam int unsigned NUM_PIPE   = sched_pkg::DEF_PIPE_REGS;
  localparam int unsigned NUM_JOBS   = 6;
  localparam int unsigned DRAIN      = 80;
  localparam int unsigned JOB_MARGIN = 200;

  logic                  clk_i;
  logic                  rst_ni;
  sched_pkg::sched_cfg_t cfg;
  sched_pkg::buf_flgs_t  flgs;
  logic                  z_empty;
  sched_pkg::x_strb_t    x_strb;
  logic                  w_load, w_shift, y_push, z_fill, reg_enable, done;

  integer                seed;
  int unsigned           err_val, err_other, cycle;
  logic                  buf_en, hold_high, jobs_ready;
  sched_pkg::sched_cfg_t job_cfg [NUM_JOBS];
  logic                  job_held [NUM_JOBS];

  // Buffer emulation state
  logic                  smp_shift, smp_load, smp_push;
  int unsigned           shift_cnt, fill_cnt, push_mod;

  `include "sched_model.svh"

  sched_top #(
    .Height      ( HEIGHT   ),
    .Width       ( WIDTH    ),
    .NumPipeRegs ( NUM_PIPE )
  ) i_sched_top (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .cfg_i        ( cfg        ),
    .flgs_i       ( flgs       ),
    .z_empty_i    ( z_empty    ),
    .x_strb_o     ( x_strb     ),
    .w_load_o     ( w_load     ),
    .w_shift_o    ( w_shift    ),
    .y_push_o     ( y_push     ),
    .z_fill_o     ( z_fill     ),
    .reg_enable_o ( reg_enable ),
    .done_o       ( done       )
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  function automatic int unsigned rand_below(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  task value_fail(input string name, input logic [31:0] got, input logic [31:0] exp);
    $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
    err_val = err_val + 1;
  endtask

  task report_fail(input string msg);
    $display("ERROR at cycle %0d: %s", cycle, msg);
    err_other = err_other + 1;
  endtask

  task check_idle();
    if (x_strb != '0) value_fail("x_strb_o", 32'(x_strb), 32'h0);
    if (w_load) value_fail("w_load_o", 32'(w_load), 32'h0);
    if (w_shift) value_fail("w_shift_o", 32'(w_shift), 32'h0);
    if (y_push) value_fail("y_push_o", 32'(y_push), 32'h0);
    if (z_fill) value_fail("z_fill_o", 32'(z_fill), 32'h0);
    if (reg_enable) value_fail("reg_enable_o", 32'(reg_enable), 32'h0);
    if (done) value_fail("done_o", 32'(done), 32'h0);
  endtask

  // The buffer model changes every flag on the rising edge
  always @(posedge clk_i) begin
    if (!buf_en) begin
      flgs      <= '0;
      z_empty   <= 1'b0;
      shift_cnt = 0;
      fill_cnt  = 0;
      push_mod  = 0;
    end else begin
      flgs.x_valid  <= 1'b1;
      flgs.w_valid  <= hold_high || rand_below(10) < 7;
      flgs.y_loaded <= hold_high || rand_below(10) < 6;
      flgs.x_empty  <= 1'b0;
      z_empty       <= 1'b0;
      if (smp_shift) shift_cnt = shift_cnt + 1;
      // The X tile is drained after HEIGHT column shifts
      if (shift_cnt == HEIGHT) begin
        shift_cnt = 0;
        flgs.x_empty <= 1'b1;
        flgs.x_full  <= 1'b0;
      end
      if (fill_cnt != 0) begin
        fill_cnt = fill_cnt - 1;
        if (fill_cnt == 0) flgs.x_full <= 1'b1;
      end else if (smp_load && !flgs.x_full) begin
        fill_cnt = 1 + rand_below(4);
      end
      if (hold_high) flgs.x_full <= 1'b1;
      if (smp_push) push_mod = push_mod + 1;
      // One Y tile has left the array after HEIGHT pushes
      if (push_mod == HEIGHT) begin
        push_mod = 0;
        z_empty  <= 1'b1;
      end
    end
  end

  // The monitor samples outputs on the falling edge where they are stable
  always @(negedge clk_i) begin
    cycle     = cycle + 1;
    smp_shift = x_strb.h_shift;
    smp_load  = x_strb.load;
    smp_push  = y_push;
    if (flgs.x_full) x_seen = 1'b1;
    if (flgs.y_loaded) y_seen = 1'b1;
    if (y_push) push_cnt = push_cnt + 1;
    if (w_load) begin
      if (!flgs.w_valid) report_fail("w_load_o pulsed while w_valid was low");
      if (!x_seen) report_fail("w_load_o pulsed before x_full was seen");
      if (cfg.y_en && !y_seen) report_fail("w_load_o pulsed before y_loaded was seen");
      if (hold_high && load_cnt != 0 && cycle - last_load != NUM_PIPE + 1) begin
        value_fail("w_load_o spacing", cycle - last_load, NUM_PIPE + 1);
      end
      load_cnt  = load_cnt + 1;
      last_load = cycle;
    end
    if (done && !done_seen) begin
      done_seen = 1'b1;
      if (load_cnt != exp_loads) value_fail("w_load_o count at done_o", load_cnt, exp_loads);
      if (cycle - last_load != 1) report_fail("done_o did not follow the final w_load_o");
    end
  end

  task build_jobs();
    for (int j = 0; j < NUM_JOBS; j++) begin
      job_cfg[j]        = '0;
      job_cfg[j].x_rows = 16'(1 + rand_below(2));
      job_cfg[j].x_cols = 16'(1 + rand_below(3));
      job_cfg[j].w_rows = 16'(1 + rand_below(4));
      job_cfg[j].w_cols = 16'(1 + rand_below(3));
      job_cfg[j].y_en   = (j == 0) || (rand_below(2) == 1);
      // The first job runs with every buffer flag held high
      job_held[j]       = (j == 0);
    end
  endtask

  task run_job(input sched_pkg::sched_cfg_t c, input logic held);
    int unsigned limit;
    int unsigned waited;
    limit  = job_cycles(c);
    waited = 0;
    @(posedge clk_i);
    cfg.clear <= 1'b1;
    buf_en    <= 1'b0;
    @(posedge clk_i);
    cfg       <= c;
    hold_high <= held;
    buf_en    <= 1'b1;
    @(negedge clk_i);
    check_idle();
    @(posedge clk_i);
    cfg.start <= 1'b1;
    start_model(c);
    @(posedge clk_i);
    cfg.start <= 1'b0;
    do begin
      @(negedge clk_i);
      waited = waited + 1;
    end while (!done && waited < limit);
    if (!done) report_fail("timeout while waiting for done_o");
    // Let the last Y push window drain
    repeat (DRAIN) @(posedge clk_i);
    if (load_cnt != exp_loads) value_fail("w_load_o count", load_cnt, exp_loads);
    if (push_cnt != exp_pushes) value_fail("y_push_o count", push_cnt, exp_pushes);
    if (!done) value_fail("done_o", 32'(done), 32'h1);
  endtask

  initial begin : watchdog
    wait (jobs_ready);
    repeat (watchdog_cycles()) @(posedge clk_i);
    $display("Watchdog expired, the simulation made no progress");
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    seed       = 32'h1e07;
    rst_ni     = 1'b0;
    cfg        = '0;
    flgs       = '0;
    z_empty    = 1'b0;
    buf_en     = 1'b0;
    hold_high  = 1'b0;
    jobs_ready = 1'b0;
    err_val    = 0;
    err_other  = 0;
    cycle      = 0;
    build_jobs();
    jobs_ready = 1'b1;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_idle();
    for (int j = 0; j < NUM_JOBS; j++) begin
      run_job(job_cfg[j], job_held[j]);
    end
    $display("Errors: %0d value, %0d other, over %0d jobs", err_val, err_other, NUM_JOBS);
    if (err_val + err_other == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- verilog/sched_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tile scheduler top level
// Connects the control FSM with the X, W and
// Z/Y controllers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module sched_top #(
  parameter int unsigned Height      = sched_pkg::DEF_HEIGHT,
  parameter int unsigned Width       = sched_pkg::DEF_WIDTH,
  parameter int unsigned NumPipeRegs = sched_pkg::DEF_PIPE_REGS
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  sched_pkg::sched_cfg_t cfg_i,
  input  sched_pkg::buf_flgs_t  flgs_i,
  input  logic                  z_empty_i,
  output sched_pkg::x_strb_t    x_strb_o,
  output logic                  w_load_o,
  output logic                  w_shift_o,
  output logic                  y_push_o,
  output logic                  z_fill_o,
  output logic                  reg_enable_o,
  output logic                  done_o
);

  sched_pkg::fsm_ctrl_t ctrl;
  logic                 x_check, y_check, col_done;

  // The window counters need at least two rows and one pipeline stage
  if (Width == 0 || Height < 2 || NumPipeRegs == 0) begin : g_size_check
    $error("sched_top: unsupported array or pipeline size");
  end

  sched_fsm #(
    .NumPipeRegs ( NumPipeRegs )
  ) i_sched_fsm (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .cfg_i        ( cfg_i        ),
    .flgs_i       ( flgs_i       ),
    .x_check_i    ( x_check      ),
    .w_done_i     ( done_o       ),
    .y_check_i    ( y_check      ),
    .ctrl_o       ( ctrl         ),
    .reg_enable_o ( reg_enable_o )
  );

  x_ctrl #(
    .Height ( Height )
  ) i_x_ctrl (
    .clk_i     ( clk_i    ),
    .rst_ni    ( rst_ni   ),
    .cfg_i     ( cfg_i    ),
    .flgs_i    ( flgs_i   ),
    .ctrl_i    ( ctrl     ),
    .strb_o    ( x_strb_o ),
    .x_check_o ( x_check  )
  );

  w_ctrl i_w_ctrl (
    .clk_i      ( clk_i     ),
    .rst_ni     ( rst_ni    ),
    .cfg_i      ( cfg_i     ),
    .flgs_i     ( flgs_i    ),
    .ctrl_i     ( ctrl      ),
    .w_load_o   ( w_load_o  ),
    .w_shift_o  ( w_shift_o ),
    .col_done_o ( col_done  ),
    .w_done_o   ( done_o    )
  );

  z_ctrl #(
    .Height      ( Height      ),
    .NumPipeRegs ( NumPipeRegs )
  ) i_z_ctrl (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .cfg_i        ( cfg_i        ),
    .z_empty_i    ( z_empty_i    ),
    .col_done_i   ( col_done     ),
    .reg_enable_i ( reg_enable_o ),
    .ctrl_i       ( ctrl         ),
    .y_push_o     ( y_push_o     ),
    .z_fill_o     ( z_fill_o     ),
    .y_check_o    ( y_check      )
  );

endmodule

//--- verilog/tile_counter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two-level tile loop counter
// Inner count wraps into the outer count, the
// outer wrap sets a sticky done flag
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module tile_counter (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         clear_i,
  input  logic                         step_i,
  input  logic [sched_pkg::ITER_W-1:0] inner_max_i,
  input  logic [sched_pkg::ITER_W-1:0] outer_max_i,
  output logic [sched_pkg::ITER_W-1:0] inner_o,
  output logic [sched_pkg::ITER_W-1:0] outer_o,
  output logic                         inner_wrap_o,
  output logic                         outer_wrap_o,
  output logic                         done_o
);

  logic [sched_pkg::ITER_W-1:0] inner_q, outer_q;
  logic                         done_q;
  logic                         step_en;

  // Once done, the loop is frozen until a clear
  assign step_en      = step_i && !done_q;
  assign inner_wrap_o = step_en && (inner_q == inner_max_i - 1'b1);
  assign outer_wrap_o = inner_wrap_o && (outer_q == outer_max_i - 1'b1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      inner_q <= '0;
      outer_q <= '0;
      done_q  <= 1'b0;
    end else if (clear_i) begin
      inner_q <= '0;
      outer_q <= '0;
      done_q  <= 1'b0;
    end else begin
      if (step_en) begin
        inner_q <= inner_wrap_o ? '0 : inner_q + 1'b1;
      end
      if (inner_wrap_o) begin
        outer_q <= outer_wrap_o ? '0 : outer_q + 1'b1;
      end
      if (outer_wrap_o) begin
        done_q <= 1'b1;
      end
    end
  end

  assign inner_o = inner_q;
  assign outer_o = outer_q;
  assign done_o  = done_q;

  a_inner_in_range : assert property (@(posedge clk_i) disable iff (!rst_ni)
    inner_o <= inner_max_i)
    else $error("tile_counter: inner count beyond its limit");

endmodule

//--- w_ctrl/w_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// W buffer controller
// Walks W rows, column tiles and matrix passes
// and strobes the weight load and shift
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module w_ctrl (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  sched_pkg::sched_cfg_t cfg_i,
  input  sched_pkg::buf_flgs_t  flgs_i,
  input  sched_pkg::fsm_ctrl_t  ctrl_i,
  output logic                  w_load_o,
  output logic                  w_shift_o,
  output logic                  col_done_o,
  output logic                  w_done_o
);

  logic [sched_pkg::ITER_W-1:0] mat_q;
  logic                         done_q;
  logic                         row_step, mat_step, done_en;

  assign w_load_o  = ctrl_i.in_load_w && ctrl_i.advance && !done_q;
  assign w_shift_o = ctrl_i.advance && !done_q;
  // The FSM only advances a weight load while w_valid is high
  assign row_step  = w_load_o;

  // Restarted after every full pass so the next X row tile sees the whole W matrix
  tile_counter i_w_iter (
    .clk_i        ( clk_i                  ),
    .rst_ni       ( rst_ni                 ),
    .clear_i      ( cfg_i.clear || mat_step ),
    .step_i       ( row_step               ),
    .inner_max_i  ( cfg_i.w_rows           ),
    .outer_max_i  ( cfg_i.w_cols           ),
    .inner_o      (                        ),
    .outer_o      (                        ),
    .inner_wrap_o ( col_done_o             ),
    .outer_wrap_o ( mat_step               ),
    .done_o       (                        )
  );

  assign done_en = mat_step && (mat_q == cfg_i.x_rows - 1'b1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mat_q  <= '0;
      done_q <= 1'b0;
    end else if (cfg_i.clear) begin
      mat_q  <= '0;
      done_q <= 1'b0;
    end else begin
      if (mat_step) mat_q <= mat_q + 1'b1;
      if (done_en) done_q <= 1'b1;
    end
  end

  assign w_done_o = done_q;

  a_load_needs_valid : assert property (@(posedge clk_i) disable iff (!rst_ni)
    w_load_o |-> flgs_i.w_valid)
    else $error("w_ctrl: weight load without a valid W row");

endmodule

//--- x_ctrl/x_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// X buffer controller
// Tracks X tiles, requests reloads and drives
// the shift, index reset and pad strobes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module x_ctrl #(
  parameter int unsigned Height = sched_pkg::DEF_HEIGHT
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  sched_pkg::sched_cfg_t cfg_i,
  input  sched_pkg::buf_flgs_t  flgs_i,
  input  sched_pkg::fsm_ctrl_t  ctrl_i,
  output sched_pkg::x_strb_t    strb_o,
  output logic                  x_check_o
);

  localparam int unsigned      ShW       = $clog2(Height);
  localparam logic [ShW-1:0]   LastShift = ShW'(Height - 1);

  logic [ShW-1:0] shift_q;
  logic           reload_q, empty_q, refill_q;
  logic           reload_en, reload_rst, shift_en, last_shift, x_done;

  // Column tiles inside, row tiles outside, one step per drained X tile
  tile_counter i_x_iter (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .clear_i      ( cfg_i.clear  ),
    .step_i       ( flgs_i.x_empty ),
    .inner_max_i  ( cfg_i.x_cols ),
    .outer_max_i  ( cfg_i.x_rows ),
    .inner_o      (              ),
    .outer_o      (              ),
    .inner_wrap_o (              ),
    .outer_wrap_o (              ),
    .done_o       ( x_done       )
  );

  // A buffer that drained while still flagged full must be reloaded once full drops
  assign reload_en  = cfg_i.start || flgs_i.x_empty || (empty_q && !flgs_i.x_full);
  assign reload_rst = flgs_i.x_full && !reload_en;

  assign shift_en   = ctrl_i.in_load_w && ctrl_i.advance;
  assign last_shift = shift_q == LastShift;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      reload_q <= 1'b0;
      empty_q  <= 1'b0;
      refill_q <= 1'b0;
      shift_q  <= '0;
    end else if (cfg_i.clear) begin
      reload_q <= 1'b0;
      empty_q  <= 1'b0;
      refill_q <= 1'b0;
      shift_q  <= '0;
    end else begin
      if (reload_rst) reload_q <= 1'b0;
      else if (reload_en) reload_q <= 1'b1;
      if (!flgs_i.x_full) empty_q <= 1'b0;
      else if (flgs_i.x_empty) empty_q <= 1'b1;
      if (strb_o.rst_w_index) refill_q <= 1'b0;
      else if (flgs_i.x_empty) refill_q <= 1'b1;
      if (shift_en) shift_q <= last_shift ? '0 : shift_q + 1'b1;
    end
  end

  assign strb_o.load        = reload_q && !reload_rst && flgs_i.x_valid;
  assign strb_o.h_shift     = shift_en;
  assign strb_o.rst_w_index = shift_en && last_shift && flgs_i.x_full;
  assign strb_o.pad_setup   = ctrl_i.preload_exit;

  // New X data is needed when the current tile has been fully shifted out
  assign x_check_o = refill_q && last_shift && !x_done;

endmodule

//--- z_ctrl/z_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Z/Y output controller
// Waits for the pipeline to drain after a W column
// tile, then opens the Y push and Z fill windows
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module z_ctrl #(
  parameter int unsigned Height      = sched_pkg::DEF_HEIGHT,
  parameter int unsigned NumPipeRegs = sched_pkg::DEF_PIPE_REGS
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  sched_pkg::sched_cfg_t cfg_i,
  input  logic                  z_empty_i,
  input  logic                  col_done_i,
  input  logic                  reg_enable_i,
  input  sched_pkg::fsm_ctrl_t  ctrl_i,
  output logic                  y_push_o,
  output logic                  z_fill_o,
  output logic                  y_check_o
);

  localparam int unsigned       WaitW    = $clog2(NumPipeRegs + 1);
  localparam int unsigned       RowW     = $clog2(Height);
  localparam logic [WaitW-1:0]  LastWait = WaitW'(NumPipeRegs);
  localparam logic [WaitW-1:0]  OpenWait = WaitW'(NumPipeRegs - 1);
  localparam logic [RowW-1:0]   LastRow  = RowW'(Height - 1);

  logic [WaitW-1:0] wait_q;
  logic [RowW-1:0]  avail_q, push_q;
  logic             wait_en_q, avail_en_q, push_en_q;
  logic             wait_clr, push_open, avail_clr, push_clr, y_done;

  // Y tiles follow the output tiles, restarted when computation begins
  tile_counter i_y_iter (
    .clk_i        ( clk_i                             ),
    .rst_ni       ( rst_ni                            ),
    .clear_i      ( cfg_i.clear || ctrl_i.start_comp  ),
    .step_i       ( z_empty_i                         ),
    .inner_max_i  ( cfg_i.w_cols                      ),
    .outer_max_i  ( cfg_i.x_rows                      ),
    .inner_o      (                                   ),
    .outer_o      (                                   ),
    .inner_wrap_o (                                   ),
    .outer_wrap_o (                                   ),
    .done_o       ( y_done                            )
  );

  assign wait_clr  = wait_en_q && ctrl_i.advance && (wait_q == LastWait);
  assign push_open = wait_en_q && ctrl_i.advance && (wait_q == OpenWait);
  assign avail_clr = avail_en_q && ctrl_i.advance && (avail_q == LastRow);
  assign push_clr  = push_en_q && ctrl_i.advance && (push_q == LastRow);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      {wait_en_q, avail_en_q, push_en_q} <= '0;
      wait_q  <= '0;
      avail_q <= '0;
      push_q  <= '0;
    end else if (cfg_i.clear) begin
      {wait_en_q, avail_en_q, push_en_q} <= '0;
      wait_q  <= '0;
      avail_q <= '0;
      push_q  <= '0;
    end else begin
      // A new window request wins over the end of the current one
      if (col_done_i) wait_en_q <= 1'b1;
      else if (wait_clr) wait_en_q <= 1'b0;
      if (wait_clr) avail_en_q <= 1'b1;
      else if (avail_clr) avail_en_q <= 1'b0;
      if (push_open) push_en_q <= 1'b1;
      else if (push_clr) push_en_q <= 1'b0;
      if (wait_en_q && ctrl_i.advance) wait_q <= (wait_q == LastWait) ? '0 : wait_q + 1'b1;
      if (avail_en_q && ctrl_i.advance) avail_q <= (avail_q == LastRow) ? '0 : avail_q + 1'b1;
      if (push_en_q && ctrl_i.advance) push_q <= (push_q == LastRow) ? '0 : push_q + 1'b1;
    end
  end

  assign y_push_o  = push_en_q && ctrl_i.advance;
  assign z_fill_o  = avail_en_q && reg_enable_i;
  assign y_check_o = cfg_i.y_en && wait_en_q && (wait_q == LastWait) && !y_done;

endmodule
